/* tests/bfs_stimulus.txt */
// hex; first word is the case count, then per case: root load nedge,
// offsets n0..n7 as {idx,cnt}, edges as mask nbr0 nbr1, levels n0..n7 (ff unreached)
5
// chain 0-1-2-3, both directions
0 1 4  01 11 21 31 00 00 00 00  2 1 0  3 0 2  3 1 3  2 2 0  0 1 2 3 ff ff ff ff
// fan-out, node 0 has six neighbors over three words, node 6 leads to 7
0 1 4  03 00 00 00 00 00 31 00  3 1 2  3 3 4  3 5 6  3 7 0  0 1 1 1 1 1 1 2
// two paths to node 4, nodes 6 and 7 unreachable from 0
0 1 7  01 11 21 31 41 00 51 61  3 1 2  2 3 0  2 4 0  2 4 0  2 5 0  3 0 7  2 6 0  0 1 1 2 2 3 ff ff
// same graph again from root 6, tables kept
6 0 0  1 2 2 3 3 4 0 1
// single-slot masks and identical neighbors
0 1 5  02 21 31 00 41 00 00 00  1 5 1  3 2 2  2 3 7  3 4 4  1 6 0  0 1 1 2 2 ff ff ff

/* sources.f */
+incdir+src
src/bfs_pkg.sv
src/bfs_queue.sv
src/bfs_graph_mem.sv
src/bfs_visited.sv
src/bfs_ctrl.sv
src/bfs_top.sv
tests/bfs_assert.sv
tests/tb_bfs.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_bfs -f sources.f -o Vtb_bfs
./obj_dir/Vtb_bfs 2>&1 | tee sim.log

if grep -qF ">>> FAIL" sim.log; then
  exit 1
fi

/* tests/tb_bfs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bfs_defines.svh"

module tb_bfs
  import bfs_pkg::*;
();

  localparam int STIM_DEPTH = 512;
  localparam int GRAPH_NODES = 8; // every test graph uses nodes 0..7
  localparam int MAX_WAIT = 4000; // 64 nodes at about 40 cycles each, rounded up
  localparam level_t UNREACHED = 8'hff;

  logic clk;
  logic bfs_rst;
  node_t root;
  logic cfg_we;
  logic cfg_sel;
  ewidx_t cfg_addr;
  pair_t cfg_wdata;
  pair_mask_t cfg_mask;
  node_t rd_node;
  logic rd_visited;
  level_t rd_level;
  logic done;

  logic [31:0] stim [STIM_DEPTH];
  int ptr;
  int level_errors;
  int flag_errors;
  int stim_errors;
  logic timed_out;

  bfs_top u_dut (
    .clk        (clk),
    .bfs_rst    (bfs_rst),
    .root       (root),
    .cfg_we     (cfg_we),
    .cfg_sel    (cfg_sel),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_mask   (cfg_mask),
    .rd_node    (rd_node),
    .rd_visited (rd_visited),
    .rd_level   (rd_level),
    .done       (done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic next_word(output logic [31:0] w);
    if (ptr >= STIM_DEPTH) begin
      $display("stimulus file ends in the middle of a test case");
      stim_errors++;
      w = '0;
    end else begin
      w = stim[ptr];
      ptr++;
    end
  endtask

  task automatic check_level(input level_t got, input level_t exp, input string name);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
      level_errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %0b expected %0b", $time, name, got, exp);
      flag_errors++;
    end
  endtask

  task automatic write_cfg(input logic sel, input ewidx_t addr, input pair_t data,
                           input pair_mask_t mask);
    @(posedge clk);
    cfg_we <= 1'b1;
    cfg_sel <= sel;
    cfg_addr <= addr;
    cfg_wdata <= data;
    cfg_mask <= mask;
  endtask

  // offsets for nodes 0..7, then edge words from index 0
  task automatic load_graph(input int nedge);
    logic [31:0] w;
    logic [31:0] mask_w;
    logic [31:0] n0;
    logic [31:0] n1;
    for (int n = 0; n < GRAPH_NODES; n++) begin
      next_word(w);
      write_cfg(1'b0, ewidx_t'(n), pair_t'(w), 2'b00);
    end
    for (int e = 0; e < nedge; e++) begin
      next_word(mask_w);
      next_word(n0);
      next_word(n1);
      write_cfg(1'b1, ewidx_t'(e), {n0, n1}, pair_mask_t'(mask_w[1:0]));
    end
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  task automatic start_search(input node_t r);
    @(posedge clk);
    root <= r;
    bfs_rst <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_flag(done, 1'b0, "done"); // low while in reset
    @(posedge clk);
    bfs_rst <= 1'b0;
  endtask

  task automatic wait_done(input int case_no);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (done !== 1'b1 && cycles < MAX_WAIT) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("case %0d: done did not rise within %0d cycles", case_no, MAX_WAIT);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_levels();
    logic [31:0] w;
    level_t exp;
    for (int n = 0; n < GRAPH_NODES; n++) begin
      next_word(w);
      exp = level_t'(w[7:0]);
      @(posedge clk);
      rd_node <= node_t'(n);
      @(negedge clk);
      check_level(rd_level, exp, $sformatf("rd_level[%0d]", n));
      check_flag(rd_visited, exp != UNREACHED, $sformatf("rd_visited[%0d]", n));
    end
    for (int n = GRAPH_NODES; n < `BFS_NODES; n++) begin
      @(posedge clk);
      rd_node <= node_t'(n);
      @(negedge clk);
      check_flag(rd_visited, 1'b0, $sformatf("rd_visited[%0d]", n)); // outside every graph
    end
    check_flag(done, 1'b1, "done"); // still high after readback
  endtask

  initial begin
    logic [31:0] num_cases;
    logic [31:0] case_root;
    logic [31:0] case_load;
    logic [31:0] case_nedge;
    bfs_rst = 1'b1; // held until the first search starts
    root = '0;
    cfg_we = 1'b0;
    cfg_sel = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    cfg_mask = '0;
    rd_node = '0;
    ptr = 0;
    level_errors = 0;
    flag_errors = 0;
    stim_errors = 0;
    timed_out = 1'b0;
    $readmemh("tests/bfs_stimulus.txt", stim);
    next_word(num_cases);
    if ($isunknown(num_cases) || num_cases == 0) begin
      $display("stimulus file holds no test cases");
      stim_errors++;
      num_cases = 0;
    end
    for (int c = 0; c < int'(num_cases) && !timed_out; c++) begin
      next_word(case_root);
      next_word(case_load);
      next_word(case_nedge);
      if (case_load != 0) load_graph(int'(case_nedge)); // 0 keeps the previous graph
      start_search(node_t'(case_root));
      wait_done(c);
      if (!timed_out) check_levels();
    end
    $display("errors: level %0d flag %0d stimulus %0d timeout %0d",
             level_errors, flag_errors, stim_errors, timed_out);
    if (level_errors + flag_errors + stim_errors == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/bfs_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module bfs_assert
  import bfs_pkg::*;
(
  input logic       clk,
  input logic       bfs_rst,
  input logic       queue_full,
  input logic       queue_empty,
  input pair_mask_t enqueue_req,
  input logic       done
);

  a_full_empty: assert property (@(posedge clk) disable iff (bfs_rst)
    !(queue_full && queue_empty))
    else $error("queue_full and queue_empty high together");

  // done only drops on a new search
  a_done_hold: assert property (@(posedge clk) $fell(done) |-> $past(bfs_rst))
    else $error("done fell without bfs_rst");

  a_no_enq_full: assert property (@(posedge clk) disable iff (bfs_rst)
    queue_full |-> enqueue_req == 2'b00)
    else $error("enqueue_req active while queue_full");

endmodule

bind bfs_queue bfs_assert u_queue_chk (
  .clk         (clk),
  .bfs_rst     (bfs_rst),
  .queue_full  (queue_full),
  .queue_empty (queue_empty),
  .enqueue_req (enqueue_req),
  .done        (1'b0)
);

bind bfs_ctrl bfs_assert u_ctrl_chk (
  .clk         (clk),
  .bfs_rst     (bfs_rst),
  .queue_full  (queue_full),
  .queue_empty (queue_empty),
  .enqueue_req (enqueue_req),
  .done        (done)
);

`default_nettype wire

/* src/bfs_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bfs_defines.svh"

module bfs_top
  import bfs_pkg::*;
(
  input  logic       clk,
  input  logic       bfs_rst,
  input  node_t      root,
  input  logic       cfg_we,
  input  logic       cfg_sel,
  input  ewidx_t     cfg_addr,
  input  pair_t      cfg_wdata,
  input  pair_mask_t cfg_mask,
  input  node_t      rd_node,
  output logic       rd_visited,
  output level_t     rd_level,
  output logic       done
);

  pair_mask_t enqueue_req;
  pair_t      wdata_in;
  logic       dequeue_req;
  node_t      rdata_out;
  logic       queue_full;
  logic       queue_empty;
  node_t      ofs_rd_node;
  ofs_t       ofs_rd_data;
  ewidx_t     edge_rd_idx;
  pair_t      edge_rd_data;
  pair_mask_t edge_rd_mask;
  node_t      chk_node0;
  node_t      chk_node1;
  logic       vis0;
  logic       vis1;
  level_t     chk_level0;
  pair_mask_t mark_en;
  node_t      mark_node0;
  node_t      mark_node1;
  level_t     mark_level;

  bfs_ctrl u_ctrl (
    .clk          (clk),
    .bfs_rst      (bfs_rst),
    .root         (root),
    .enqueue_req  (enqueue_req),
    .wdata_in     (wdata_in),
    .dequeue_req  (dequeue_req),
    .rdata_out    (rdata_out),
    .queue_full   (queue_full),
    .queue_empty  (queue_empty),
    .ofs_rd_node  (ofs_rd_node),
    .ofs_rd_data  (ofs_rd_data),
    .edge_rd_idx  (edge_rd_idx),
    .edge_rd_data (edge_rd_data),
    .edge_rd_mask (edge_rd_mask),
    .chk_node0    (chk_node0),
    .chk_node1    (chk_node1),
    .vis0         (vis0),
    .vis1         (vis1),
    .chk_level0   (chk_level0),
    .mark_en      (mark_en),
    .mark_node0   (mark_node0),
    .mark_node1   (mark_node1),
    .mark_level   (mark_level),
    .done         (done)
  );

  bfs_queue #(
    .Q_SIZE (`BFS_Q_SIZE)
  ) u_queue (
    .clk         (clk),
    .bfs_rst     (bfs_rst),
    .enqueue_req (enqueue_req),
    .wdata_in    (wdata_in),
    .dequeue_req (dequeue_req),
    .rdata_out   (rdata_out),
    .queue_full  (queue_full),
    .queue_empty (queue_empty)
  );

  bfs_graph_mem u_graph_mem (
    .clk          (clk),
    .cfg_we       (cfg_we),
    .cfg_sel      (cfg_sel),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_mask     (cfg_mask),
    .ofs_rd_node  (ofs_rd_node),
    .ofs_rd_data  (ofs_rd_data),
    .edge_rd_idx  (edge_rd_idx),
    .edge_rd_data (edge_rd_data),
    .edge_rd_mask (edge_rd_mask)
  );

  bfs_visited u_visited (
    .clk        (clk),
    .bfs_rst    (bfs_rst),
    .chk_node0  (chk_node0),
    .chk_node1  (chk_node1),
    .vis0       (vis0),
    .vis1       (vis1),
    .chk_level0 (chk_level0),
    .mark_en    (mark_en),
    .mark_node0 (mark_node0),
    .mark_node1 (mark_node1),
    .mark_level (mark_level),
    .rd_node    (rd_node),
    .rd_visited (rd_visited),
    .rd_level   (rd_level)
  );

endmodule

`default_nettype wire

/* src/bfs_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bfs_defines.svh"

module bfs_ctrl
  import bfs_pkg::*;
(
  input  logic       clk,
  input  logic       bfs_rst,
  input  node_t      root,
  output pair_mask_t enqueue_req,
  output pair_t      wdata_in,
  output logic       dequeue_req,
  input  node_t      rdata_out,
  input  logic       queue_full,
  input  logic       queue_empty,
  output node_t      ofs_rd_node,
  input  ofs_t       ofs_rd_data,
  output ewidx_t     edge_rd_idx,
  input  pair_t      edge_rd_data,
  input  pair_mask_t edge_rd_mask,
  output node_t      chk_node0,
  output node_t      chk_node1,
  input  logic       vis0,
  input  logic       vis1,
  input  level_t     chk_level0,
  output pair_mask_t mark_en,
  output node_t      mark_node0,
  output node_t      mark_node1,
  output level_t     mark_level,
  output logic       done
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  level_t cur_level;
  ewidx_t edge_idx;
  ecnt_t edge_cnt;
  pair_mask_t enq_mask;
  pair_mask_t new_mask;
  ecnt_t ofs_cnt;
  node_t nbr0;
  node_t nbr1;
  logic enq_go;

  assign nbr0 = edge_rd_data[2*`BFS_NODE_W-1:`BFS_NODE_W];
  assign nbr1 = edge_rd_data[`BFS_NODE_W-1:0];
  assign ofs_cnt = ofs_rd_data[$bits(ecnt_t)-1:0];

  // keep valid unvisited slots and drop a duplicate in slot 1
  assign new_mask[1] = edge_rd_mask[1] & ~vis0;
  assign new_mask[0] = edge_rd_mask[0] & ~vis1 & ~(edge_rd_mask[1] && nbr0 == nbr1);

  assign enq_go = ~queue_full | (enq_mask == '0); // an empty mask never stalls

  always_comb begin
    state_next = state;
    case (state)
      POP:        state_next = queue_empty ? FINISH : FETCH_OFS;
      FETCH_OFS:  state_next = (ofs_cnt == '0) ? POP : FETCH_EDGE;
      FETCH_EDGE: state_next = CHECK;
      CHECK:      state_next = ENQ;
      ENQ: begin
        if (enq_go) state_next = (edge_cnt == ecnt_t'(1)) ? POP : FETCH_EDGE;
      end
      FINISH:     state_next = FINISH;
      default:    state_next = POP;
    endcase
  end

  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      state <= POP;
      done <= 1'b0;
      cur_level <= '0;
      edge_idx <= '0;
      edge_cnt <= '0;
      enq_mask <= '0;
    end else begin
      state <= state_next;
      case (state)
        POP: begin
          if (queue_empty) done <= 1'b1; // frontier drained
          else cur_level <= chk_level0;
        end
        FETCH_OFS: {edge_idx, edge_cnt} <= ofs_rd_data;
        CHECK: enq_mask <= new_mask;
        ENQ: begin
          if (enq_go) begin
            edge_idx <= edge_idx + 1'b1;
            edge_cnt <= edge_cnt - 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  assign dequeue_req = (state == POP) & ~queue_empty;
  assign ofs_rd_node = rdata_out; // offset read issued with the pop
  assign edge_rd_idx = edge_idx;

  assign chk_node0 = (state == POP) ? rdata_out : nbr0;
  assign chk_node1 = nbr1;

  // root goes in slot 1 during reset
  assign enqueue_req = bfs_rst ? 2'b01 :
                       (state == ENQ && !queue_full) ? enq_mask : 2'b00;
  assign wdata_in = bfs_rst ? {node_t'(0), root} : edge_rd_data;

  assign mark_en = bfs_rst ? 2'b01 : (state == CHECK) ? new_mask : 2'b00;
  assign mark_node0 = wdata_in[2*`BFS_NODE_W-1:`BFS_NODE_W];
  assign mark_node1 = wdata_in[`BFS_NODE_W-1:0];
  assign mark_level = bfs_rst ? level_t'(0) : level_t'(cur_level + 1'b1);

endmodule

`default_nettype wire

/* src/bfs_visited.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bfs_defines.svh"

module bfs_visited
  import bfs_pkg::*;
(
  input  logic       clk,
  input  logic       bfs_rst,
  input  node_t      chk_node0,
  input  node_t      chk_node1,
  output logic       vis0,
  output logic       vis1,
  output level_t     chk_level0,
  input  pair_mask_t mark_en,
  input  node_t      mark_node0,
  input  node_t      mark_node1,
  input  level_t     mark_level,
  input  node_t      rd_node,
  output logic       rd_visited,
  output level_t     rd_level
);

  localparam int NAW = $clog2(`BFS_NODES);

  logic [`BFS_NODES-1:0] visited;
  level_t level_mem [`BFS_NODES];

  // clear first, marks land on top so the root mark survives reset
  always_ff @(posedge clk) begin
    if (bfs_rst) visited <= '0;
    if (mark_en[1]) visited[mark_node0[NAW-1:0]] <= 1'b1;
    if (mark_en[0]) visited[mark_node1[NAW-1:0]] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (mark_en[1]) level_mem[mark_node0[NAW-1:0]] <= mark_level;
    if (mark_en[0]) level_mem[mark_node1[NAW-1:0]] <= mark_level;
  end

  assign vis0 = visited[chk_node0[NAW-1:0]];
  assign vis1 = visited[chk_node1[NAW-1:0]];
  assign chk_level0 = level_mem[chk_node0[NAW-1:0]]; // level of popped node

  assign rd_visited = visited[rd_node[NAW-1:0]];
  assign rd_level = rd_visited ? level_mem[rd_node[NAW-1:0]] : '1; // 255 if unreached

endmodule

`default_nettype wire

/* src/bfs_graph_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bfs_defines.svh"

module bfs_graph_mem
  import bfs_pkg::*;
(
  input  logic       clk,
  input  logic       cfg_we,
  input  logic       cfg_sel,
  input  ewidx_t     cfg_addr,
  input  pair_t      cfg_wdata,
  input  pair_mask_t cfg_mask,
  input  node_t      ofs_rd_node,
  output ofs_t       ofs_rd_data,
  input  ewidx_t     edge_rd_idx,
  output pair_t      edge_rd_data,
  output pair_mask_t edge_rd_mask
);

  localparam int NAW = $clog2(`BFS_NODES);

  ofs_t       ofs_mem  [`BFS_NODES];
  pair_t      edge_mem [`BFS_EDGE_WORDS];
  pair_mask_t mask_mem [`BFS_EDGE_WORDS];

  // host load, sel 0 = offsets, sel 1 = edge words
  always_ff @(posedge clk) begin
    if (cfg_we && !cfg_sel) begin
      ofs_mem[cfg_addr[NAW-1:0]] <= cfg_wdata[$bits(ofs_t)-1:0];
    end
    if (cfg_we && cfg_sel) begin
      edge_mem[cfg_addr] <= cfg_wdata;
      mask_mem[cfg_addr] <= cfg_mask; // mask kept beside its word
    end
  end

  always_ff @(posedge clk) begin
    ofs_rd_data <= ofs_mem[ofs_rd_node[NAW-1:0]];
  end

  always_ff @(posedge clk) begin
    edge_rd_data <= edge_mem[edge_rd_idx];
    edge_rd_mask <= mask_mem[edge_rd_idx];
  end

endmodule

`default_nettype wire

/* src/bfs_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bfs_defines.svh"

module bfs_queue
  import bfs_pkg::*;
#(
  parameter int Q_SIZE = 64
) (
  input  logic       clk,
  input  logic       bfs_rst,
  input  pair_mask_t enqueue_req,
  input  pair_t      wdata_in,
  input  logic       dequeue_req,
  output node_t      rdata_out,
  output logic       queue_full,
  output logic       queue_empty
);

  localparam int AW = $clog2(Q_SIZE);

  node_t slot0_mem [Q_SIZE];
  node_t slot1_mem [Q_SIZE];
  logic [Q_SIZE-1:0] valid0;
  logic [Q_SIZE-1:0] valid1;

  logic [AW-1:0] head;
  logic [AW-1:0] tail;
  logic head_wrap;
  logic tail_wrap;
  logic [AW-1:0] enq_idx;
  logic enq_ok;
  logic deq_ok;
  logic head_last;

  assign enq_idx = bfs_rst ? '0 : tail; // root always lands in entry 0
  assign enq_ok = (|enqueue_req) & (~queue_full | bfs_rst);
  assign deq_ok = dequeue_req & ~queue_empty & ~bfs_rst;
  assign head_last = valid0[head] ^ valid1[head]; // one slot left in head entry

  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      valid0 <= '0;
      valid1 <= '0;
    end else if (deq_ok) begin
      if (valid0[head]) valid0[head] <= 1'b0; // slot 0 goes first
      else valid1[head] <= 1'b0;
    end
    if (enq_ok) begin
      valid0[enq_idx] <= enqueue_req[1];
      valid1[enq_idx] <= enqueue_req[0];
    end
  end

  always_ff @(posedge clk) begin
    if (enq_ok) begin
      slot0_mem[enq_idx] <= wdata_in[2*`BFS_NODE_W-1:`BFS_NODE_W];
      slot1_mem[enq_idx] <= wdata_in[`BFS_NODE_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (bfs_rst) begin
      {head_wrap, head} <= '0;
      {tail_wrap, tail} <= {{AW{1'b0}}, |enqueue_req}; // root insertion
    end else begin
      if (deq_ok && head_last) {head_wrap, head} <= {head_wrap, head} + 1'b1;
      if (enq_ok) {tail_wrap, tail} <= {tail_wrap, tail} + 1'b1;
    end
  end

  assign rdata_out = valid0[head] ? slot0_mem[head] : slot1_mem[head];
  assign queue_full = (head_wrap ^ tail_wrap) & (head == tail);
  assign queue_empty = ~(head_wrap ^ tail_wrap) & (head == tail);

endmodule

`default_nettype wire

/* src/bfs_pkg.sv */
`default_nettype none

`include "bfs_defines.svh"

package bfs_pkg;

  typedef logic [`BFS_NODE_W-1:0] node_t;
  typedef logic [2*`BFS_NODE_W-1:0] pair_t; // slot 0 high, slot 1 low
  typedef logic [1:0] pair_mask_t; // bit 1 -> slot 0, bit 0 -> slot 1
  typedef logic [`BFS_LEVEL_W-1:0] level_t;

  typedef logic [$clog2(`BFS_EDGE_WORDS)-1:0] ewidx_t;
  typedef logic [3:0] ecnt_t; // edge words per node
  // offset entry is {first word index, word count}
  typedef logic [$bits(ewidx_t)+$bits(ecnt_t)-1:0] ofs_t;

  typedef enum logic [2:0] {
    POP,
    FETCH_OFS,
    FETCH_EDGE,
    CHECK,
    ENQ,
    FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire

/* src/bfs_defines.svh */
`ifndef BFS_DEFINES_SVH
`define BFS_DEFINES_SVH

// graph size limits
`define BFS_NODES 64
`define BFS_EDGE_WORDS 128

// frontier queue depth in dual-slot entries
`define BFS_Q_SIZE 64

// field widths
`define BFS_NODE_W 32
`define BFS_LEVEL_W 8

`endif
